/* hdl/count_collector.sv */
`timescale 1ns/1ns

module count_collector import lincrypt_pkg::*; #(
    parameter int LANES = 4
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    restart,
    input  logic                    lane_start,
    input  lane_result_t [LANES-1:0] lane_results,
    output logic                    busy,
    output count_t                  total_count,
    output logic                    done
);

    logic   all_done;
    count_t sum;

    always_comb begin
        all_done = 1'b1;
        sum      = '0;
        for (int i = 0; i < LANES; i++) begin
            all_done = all_done && lane_results[i].done;
            sum      = sum + lane_results[i].count;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || restart) begin
            busy        <= 1'b0;
            done        <= 1'b0;
            total_count <= '0;
        end else begin
            if (lane_start) busy <= 1'b1;  // stays set past done, until restart
            if (all_done && !done) begin
                total_count <= sum;         // lane counts are frozen by now
                done        <= 1'b1;
            end
        end
    end

endmodule

/* hdl/des_pipeline.sv */
`timescale 1ns/1ns

module des_pipeline import lincrypt_pkg::*; #(
    parameter logic [767:0] ROUND_KEYS = '0     // round key 1 in the top 48 bits
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        restart,
    input  logic [63:0] message,
    input  logic        in_valid,
    output des_state_t  out
);

    des_state_t  stage [DES_STAGES];    // stage 0 is the input register
    logic [63:0] ip_msg;
    logic [63:0] cipher;

    assign ip_msg = des_ip(message);

    always_ff @(posedge clk) begin
        stage[0].l <= ip_msg[63:32];
        stage[0].r <= ip_msg[31:0];
        if (!rst_n || restart) begin
            stage[0].valid <= 1'b0;
        end else begin
            stage[0].valid <= in_valid;
        end
    end

    for (genvar g = 0; g < DES_STAGES - 1; g++) begin : g_round
        des_round u_round (
            .clk       (clk),
            .rst_n     (rst_n),
            .restart   (restart),
            .round_key (ROUND_KEYS[767 - 48 * g -: 48]),   // round g+1
            .in        (stage[g]),
            .out       (stage[g + 1])
        );
    end

    // last round is not swapped, so undo it before fp
    assign cipher = des_fp({stage[DES_STAGES - 1].r, stage[DES_STAGES - 1].l});
    assign out    = {stage[DES_STAGES - 1].valid, cipher};

endmodule

/* hdl/des_round.sv */
`timescale 1ns/1ns

module des_round import lincrypt_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        restart,
    input  logic [47:0] round_key,
    input  des_state_t  in,
    output des_state_t  out
);

    logic [31:0] f_out;     // feistel output for this round

    assign f_out = des_f(in.r, round_key);

    always_ff @(posedge clk) begin
        out.l <= in.r;                  // halves swap every round
        out.r <= in.l ^ f_out;
        // only the valid bit is control, halves are plain payload
        if (!rst_n || restart) begin
            out.valid <= 1'b0;
        end else begin
            out.valid <= in.valid;
        end
    end

endmodule

/* hdl/lincrypt_lane.sv */
`timescale 1ns/1ns

module lincrypt_lane import lincrypt_pkg::*; #(
    parameter int           REGION_W   = 58,
    parameter logic [63:0]  MASK_I     = 64'h1,
    parameter logic [63:0]  MASK_O     = 64'h1,
    parameter logic [767:0] ROUND_KEYS = '0
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                lane_start,
    input  logic                restart,
    input  logic [REGION_W-1:0] region,
    output lane_result_t        result
);

    typedef enum logic [1:0] {
        idle,
        working,
        finishing,      // last message issued, pipeline draining
        finished
    } lane_state_t;

    lane_state_t           state, next_state;
    logic [63:0]           message;
    logic                  msg_valid;
    logic                  msg_last;
    logic                  msg_start;
    des_state_t            cipher;
    logic                  cipher_valid_q;     // for the falling edge of output valid
    logic [DES_STAGES-1:0] parity_dly;         // input parity, aligned with the pipeline
    logic                  hit;
    count_t                count;

    assign msg_start = lane_start && (state == idle);  // ignored once a run is going

    message_counter_partial #(.REGION_W(REGION_W)) u_msg (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (msg_start),
        .restart (restart),
        .region  (region),
        .message (message),
        .valid   (msg_valid),
        .last    (msg_last)
    );

    des_pipeline #(.ROUND_KEYS(ROUND_KEYS)) u_des (
        .clk      (clk),
        .rst_n    (rst_n),
        .restart  (restart),
        .message  (message),
        .in_valid (msg_valid),
        .out      (cipher)
    );

    always_ff @(posedge clk) begin
        if (!rst_n || restart) begin
            state <= idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            idle:      if (lane_start) next_state = working;
            working:   if (msg_last) next_state = finishing;
            finishing: if (cipher_valid_q && !cipher.valid) next_state = finished;
            finished:  next_state = finished;             // held until restart
            default:   next_state = idle;
        endcase
    end

    // pipeline never stalls, so a plain shift line keeps the parity in step
    always_ff @(posedge clk) begin
        parity_dly <= {parity_dly[DES_STAGES-2:0], mask_parity(message, MASK_I)};
    end

    assign hit = cipher.valid
        && (mask_parity({cipher.l, cipher.r}, MASK_O) ^ parity_dly[DES_STAGES-1]);

    always_ff @(posedge clk) begin
        if (!rst_n || restart) begin
            count          <= '0;
            cipher_valid_q <= 1'b0;
        end else begin
            cipher_valid_q <= cipher.valid;
            if (hit) count <= count + 1'b1;         // approximation holds as 1
        end
    end

    assign result.done  = (state == finished);
    assign result.count = count;

endmodule

/* hdl/lincrypt_pkg.sv */
package lincrypt_pkg;

    localparam int DES_STAGES = 17;         // input register + 16 rounds

    typedef logic [63:0] count_t;           // hit count, wide enough for any region width

    typedef struct packed {
        logic        valid;
        logic [31:0] l;                     // left half
        logic [31:0] r;                     // right half
    } des_state_t;

    typedef struct packed {
        logic   done;                       // level, held until restart
        count_t count;
    } lane_result_t;

    // tables use des bit numbering, bit 1 is the msb
    localparam byte unsigned IP_TAB [64] = '{
        58, 50, 42, 34, 26, 18, 10,  2, 60, 52, 44, 36, 28, 20, 12,  4,
        62, 54, 46, 38, 30, 22, 14,  6, 64, 56, 48, 40, 32, 24, 16,  8,
        57, 49, 41, 33, 25, 17,  9,  1, 59, 51, 43, 35, 27, 19, 11,  3,
        61, 53, 45, 37, 29, 21, 13,  5, 63, 55, 47, 39, 31, 23, 15,  7
    };

    localparam byte unsigned FP_TAB [64] = '{
        40,  8, 48, 16, 56, 24, 64, 32, 39,  7, 47, 15, 55, 23, 63, 31,
        38,  6, 46, 14, 54, 22, 62, 30, 37,  5, 45, 13, 53, 21, 61, 29,
        36,  4, 44, 12, 52, 20, 60, 28, 35,  3, 43, 11, 51, 19, 59, 27,
        34,  2, 42, 10, 50, 18, 58, 26, 33,  1, 41,  9, 49, 17, 57, 25
    };

    localparam byte unsigned E_TAB [48] = '{
        32,  1,  2,  3,  4,  5,  4,  5,  6,  7,  8,  9,  8,  9, 10, 11,
        12, 13, 12, 13, 14, 15, 16, 17, 16, 17, 18, 19, 20, 21, 20, 21,
        22, 23, 24, 25, 24, 25, 26, 27, 28, 29, 28, 29, 30, 31, 32,  1
    };

    localparam byte unsigned P_TAB [32] = '{
        16,  7, 20, 21, 29, 12, 28, 17,  1, 15, 23, 26,  5, 18, 31, 10,
         2,  8, 24, 14, 32, 27,  3,  9, 19, 13, 30,  6, 22, 11,  4, 25
    };

    // one nibble per entry, row * 16 + column, entry 0 in the top nibble
    localparam logic [255:0] SBOX [8] = '{
        256'hE4D12FB83A6C5907_0F74E2D1A6CB9538_41E8D62BFC973A50_FC8249175B3EA06D,
        256'hF18E6B34972DC05A_3D47F28EC01A69B5_0E7BA4D158C6932F_D8A13F42B67C05E9,
        256'hA09E63F51DC7B428_D70934A6285ECBF1_D6498F30B12C5AE7_1AD069874FE3B52C,
        256'h7DE3069A1285BC4F_D8B56F03472C1AE9_A690CB7DF13E5284_3F06A1D8945BC72E,
        256'h2C417AB6853FD0E9_EB2C47D150FA3986_421BAD78F9C5630E_B8C71E2D6F09A453,
        256'hC1AF92680D34E75B_AF427C9561DE0B38_9EF528C3704A1DB6_432C95FABE17608D,
        256'h4B2EF08D3C975A61_D0B7491AE35C2F86_14BDC37EAF680592_6BD814A7950FE23C,
        256'hD2846FB1A93E50C7_1FD8A374C56B0E92_7B419CE206ADF358_21E74A8DFC90356B
    };

    function automatic logic [63:0] des_ip(input logic [63:0] x);
        logic [63:0] y;
        for (int i = 0; i < 64; i++) begin
            y[63 - i] = x[64 - IP_TAB[i]];
        end
        return y;
    endfunction

    function automatic logic [63:0] des_fp(input logic [63:0] x);
        logic [63:0] y;
        for (int i = 0; i < 64; i++) begin
            y[63 - i] = x[64 - FP_TAB[i]];
        end
        return y;
    endfunction

    // feistel function: expand, key mix, s-boxes, p permutation
    function automatic logic [31:0] des_f(input logic [31:0] r, input logic [47:0] k);
        logic [47:0] e;
        logic [5:0]  six;
        logic [5:0]  idx;
        logic [31:0] s_out;
        logic [31:0] f;
        for (int i = 0; i < 48; i++) begin
            e[47 - i] = r[32 - E_TAB[i]];
        end
        e = e ^ k;
        for (int s = 0; s < 8; s++) begin
            six = e[47 - 6 * s -: 6];
            idx = {six[5], six[0], six[4:1]};       // outer bits pick the row
            s_out[31 - 4 * s -: 4] = SBOX[s][255 - 4 * int'(idx) -: 4];
        end
        for (int i = 0; i < 32; i++) begin
            f[31 - i] = s_out[32 - P_TAB[i]];
        end
        return f;
    endfunction

    function automatic logic mask_parity(input logic [63:0] x, input logic [63:0] mask);
        return ^(x & mask);
    endfunction

endpackage

/* hdl/lincrypt_top.sv */
`timescale 1ns/1ns

module lincrypt_top import lincrypt_pkg::*; #(
    parameter int           REGION_W   = 58,
    parameter int           LANES      = 4,
    parameter logic [63:0]  MASK_I     = 64'h0000_0800_0000_0021,
    parameter logic [63:0]  MASK_O     = 64'h0104_0000_0000_8000,
    parameter logic [767:0] ROUND_KEYS = {16{48'h0b02_67e3_9a51}}
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    input  logic                     restart,
    input  logic [REGION_W-1:0]      base_region,
    output lane_result_t [LANES-1:0] lane_results,
    output count_t                   total_count,
    output logic                     done
);

    logic                           lane_start;
    logic [LANES-1:0][REGION_W-1:0] lane_region;
    logic                           busy;

    region_dispatch #(.REGION_W(REGION_W), .LANES(LANES)) u_dispatch (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .restart     (restart),
        .busy        (busy),
        .base_region (base_region),
        .lane_start  (lane_start),
        .lane_region (lane_region)
    );

    for (genvar i = 0; i < LANES; i++) begin : g_lane
        lincrypt_lane #(
            .REGION_W   (REGION_W),
            .MASK_I     (MASK_I),
            .MASK_O     (MASK_O),
            .ROUND_KEYS (ROUND_KEYS)
        ) u_lane (
            .clk        (clk),
            .rst_n      (rst_n),
            .lane_start (lane_start),
            .restart    (restart),
            .region     (lane_region[i]),
            .result     (lane_results[i])
        );
    end

    count_collector #(.LANES(LANES)) u_collect (
        .clk          (clk),
        .rst_n        (rst_n),
        .restart      (restart),
        .lane_start   (lane_start),
        .lane_results (lane_results),
        .busy         (busy),
        .total_count  (total_count),
        .done         (done)
    );

endmodule

/* hdl/message_counter_partial.sv */
`timescale 1ns/1ns

module message_counter_partial #(
    parameter int REGION_W = 58
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    input  logic                restart,
    input  logic [REGION_W-1:0] region,
    output logic [63:0]         message,
    output logic                valid,
    output logic                last
);

    localparam int IDX_W = 64 - REGION_W;  // message index bits within one region

    logic [REGION_W-1:0] region_q;
    logic [IDX_W-1:0]    index;

    always_ff @(posedge clk) begin
        if (!rst_n || restart) begin
            valid <= 1'b0;
        end else if (start) begin
            valid <= 1'b1;                  // first message on the next cycle
        end else if (last) begin
            valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            region_q <= region;             // region held for the whole sweep
            index    <= '0;
        end else if (valid) begin
            index <= index + 1'b1;
        end
    end

    assign message = {region_q, index};
    assign last    = valid && (index == '1); // all ones is the final message

endmodule

/* hdl/region_dispatch.sv */
`timescale 1ns/1ns

module region_dispatch #(
    parameter int REGION_W = 58,
    parameter int LANES    = 4
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           start,
    input  logic                           restart,
    input  logic                           busy,
    input  logic [REGION_W-1:0]            base_region,
    output logic                           lane_start,
    output logic [LANES-1:0][REGION_W-1:0] lane_region
);

    logic accept;   // start taken only when nothing is running

    // lane_start also blocks, busy is one cycle late
    assign accept = start && !busy && !lane_start;

    always_ff @(posedge clk) begin
        if (!rst_n || restart) begin
            lane_start <= 1'b0;
        end else begin
            lane_start <= accept;           // one pulse shared by all lanes
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            for (int i = 0; i < LANES; i++) begin
                lane_region[i] <= base_region + REGION_W'(i);  // wraps mod 2^N
            end
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the lincrypt testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module lincrypt_tb -o lincrypt_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/lincrypt_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi
exit 0

/* sim.f */
hdl/lincrypt_pkg.sv
hdl/des_round.sv
hdl/des_pipeline.sv
hdl/message_counter_partial.sv
hdl/lincrypt_lane.sv
hdl/region_dispatch.sv
hdl/count_collector.sv
hdl/lincrypt_top.sv
testbench/lincrypt_tb.sv

/* testbench/lincrypt_tb.sv */
`timescale 1ns/1ns

module lincrypt_tb import lincrypt_pkg::*; ();

    localparam int           REGION_W = 58;
    localparam int           LANES    = 4;
    localparam int           IDX_W    = 64 - REGION_W;
    localparam int           MSGS     = 1 << IDX_W;       // messages per region
    localparam logic [63:0]  MASK_I   = 64'h0000_0000_2104_0080;
    localparam logic [63:0]  MASK_O   = 64'h2104_0080_0000_8000;
    localparam logic [767:0] KEYS     = {
        48'h1b02_effc_7072, 48'h79ae_d9db_c9e5, 48'h55fc_8a42_cf99, 48'h72ad_d6db_351d,
        48'h7cec_07eb_53a8, 48'h63a5_3e50_7b2f, 48'hec84_b7f6_18bc, 48'hf78a_3ac1_3bfb,
        48'he0db_ebed_e781, 48'hb1f3_47ba_464f, 48'h215f_d3de_d386, 48'h7571_f594_67e9,
        48'h97c5_d1fa_ba41, 48'h5f43_b7f2_e73a, 48'hbf91_8d3d_3f0a, 48'hcb3d_8b0e_17f5
    };
    // 8 runs of sweep + pipeline + overhead plus margin
    localparam int           LIMIT    = 8 * (MSGS + DES_STAGES + 10) + 272;

    logic                     clk;
    logic                     rst_n;
    logic                     start;
    logic                     restart;
    logic [REGION_W-1:0]      base_region;
    lane_result_t [LANES-1:0] lane_results;
    count_t                   total_count;
    logic                     done;

    logic [63:0]              rng;         // xorshift state
    int                       cycles;

    lincrypt_top #(
        .REGION_W   (REGION_W),
        .LANES      (LANES),
        .MASK_I     (MASK_I),
        .MASK_O     (MASK_O),
        .ROUND_KEYS (KEYS)
    ) dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .restart      (restart),
        .base_region  (base_region),
        .lane_results (lane_results),
        .total_count  (total_count),
        .done         (done)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;            // 100 ns period
    end

    initial begin
        cycles = 0;
        while (cycles < LIMIT) begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        $display("timeout: the run did not finish within %0d cycles", LIMIT);
        $display("TEST FAIL");
        $fatal(1);
    end

    function automatic logic [63:0] xorshift(input logic [63:0] s);
        logic [63:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 7);
        x = x ^ (x << 17);
        return x;
    endfunction

    // reference des with one round per loop pass
    function automatic logic [63:0] des_encrypt(input logic [63:0] pt);
        logic [63:0] ip;
        logic [31:0] l;
        logic [31:0] r;
        logic [31:0] t;
        ip = des_ip(pt);
        l  = ip[63:32];
        r  = ip[31:0];
        for (int g = 0; g < 16; g++) begin
            t = r;
            r = l ^ des_f(r, KEYS[767 - 48 * g -: 48]);   // key 1 on top
            l = t;
        end
        return des_fp({r, l});                 // no swap after round 16
    endfunction

    // hits of the linear approximation over one region
    function automatic count_t model_count(input logic [REGION_W-1:0] region);
        count_t      cnt;
        logic [63:0] pt;
        cnt = '0;
        for (int j = 0; j < MSGS; j++) begin
            pt = {region, j[IDX_W-1:0]};
            if (mask_parity(pt, MASK_I) ^ mask_parity(des_encrypt(pt), MASK_O)) begin
                cnt = cnt + 64'd1;
            end
        end
        return cnt;
    endfunction

    task automatic check_lane(input int idx, input lane_result_t got, input lane_result_t exp);
        if (got !== exp) begin
            $display("Error: lane_results[%0d] = %h, expected %h", idx, got, exp);
            $display("TEST FAIL");
            $fatal(1);
        end
    endtask

    task automatic check_total(input count_t got, input count_t exp);
        if (got !== exp) begin
            $display("Error: total_count = %h, expected %h", got, exp);
            $display("TEST FAIL");
            $fatal(1);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error: %s = %h, expected %h", name, got, exp);
            $display("TEST FAIL");
            $fatal(1);
        end
    endtask

    task automatic pulse_start(input logic [REGION_W-1:0] base);
        @(posedge clk);
        start       <= 1'b1;
        base_region <= base;
        @(posedge clk);
        start       <= 1'b0;
    endtask

    task automatic pulse_restart();
        @(posedge clk);
        restart <= 1'b1;
        @(posedge clk);
        restart <= 0;
    endtask

    task automatic wait_done();
        while (done !== 1'b1) @(negedge clk);   // done rises once every lane has drained
    endtask

    task automatic verify_cleared();
        lane_result_t zero;
        zero = '0;
        check_flag("done", done, 1'b0);
        for (int i = 0; i < LANES; i++) check_lane(i, lane_results[i], zero);
        check_total(total_count, '0);
    endtask

    task automatic verify_run(input logic [REGION_W-1:0] base);
        lane_result_t exp;
        count_t       sum;
        sum = '0;
        check_flag("done", done, 1'b1);
        for (int i = 0; i < LANES; i++) begin
            exp.done  = 1'b1;
            exp.count = model_count(base + REGION_W'(i));   // wraps mod 2^58
            check_lane(i, lane_results[i], exp);
            sum = sum + exp.count;
        end
        check_total(total_count, sum);
    endtask

    task automatic run_region(input logic [REGION_W-1:0] base);
        pulse_restart();
        @(negedge clk);
        verify_cleared();
        pulse_start(base);
        wait_done();
        verify_run(base);
    endtask

    initial begin
        logic [REGION_W-1:0] base;
        int                  wait_cycles;
        rng         = 64'd39576;
        start       <= 1'b0;
        restart     <= 1'b0;
        base_region <= '0;
        rst_n       <= 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        verify_cleared();                   // state right after reset

        for (int r = 0; r < 4; r++) begin   // random regions
            rng  = xorshift(rng);
            base = rng[REGION_W-1:0];
            run_region(base);
        end

        base = 58'h3ff_ffff_ffff_fffe;      // lanes 2 and 3 wrap to 0 and 1
        run_region(base);

        // a second start is ignored while the result is held
        rng = xorshift(rng);
        pulse_start(rng[REGION_W-1:0]);
        repeat (10) @(negedge clk);
        verify_run(base);

        // restart in mid sweep and then a clean run
        rng  = xorshift(rng);
        base = rng[REGION_W-1:0];
        pulse_restart();
        pulse_start(base);
        rng         = xorshift(rng);
        wait_cycles = 2 * DES_STAGES + int'(rng[4:0]);  // counts already moving, done far off
        repeat (wait_cycles) @(posedge clk);
        pulse_restart();
        @(negedge clk);
        verify_cleared();
        rng  = xorshift(rng);
        base = rng[REGION_W-1:0];
        run_region(base);

        $display("TEST PASS");
        $finish;
    end

endmodule
